// File: verilog/masterPkg.sv
`default_nettype none

package masterPkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int memDepth = 256;
    localparam int dataWidth = 16;
    localparam int addrWidth = $clog2(memDepth);
    localparam int slaveIdWidth = 2;

    // leads both the request frame and the header
    localparam logic [2:0] startCode = 3'b111;

    // consecutive high arbCont samples that make a grant
    localparam int grantSamples = 3;

    ////////////////////
    // payload types
    ////////////////////
    typedef logic [dataWidth-1:0] dataT;
    typedef logic [addrWidth-1:0] addrT;
    typedef logic [slaveIdWidth-1:0] slaveIdT;

    // sent msb first on arbSend
    typedef struct packed {
        logic [2:0] code;
        slaveIdT    slaveId;
    } requestT;

    // sent msb first on control, 14 bits
    typedef struct packed {
        logic [2:0] code;
        slaveIdT    slaveId;
        logic       rdWr;
        addrT       address;
    } headerT;

    typedef enum logic [2:0] {
        idle, request, waitBus, header, writeData, readData, store, finish
    } seqStateT;

endpackage

`default_nettype wire

// File: verilog/localRam.sv
`timescale 1ns/10ps
`default_nettype none

module localRam (
    input  wire logic           clk,
    input  wire logic           aWe,
    input  wire masterPkg::addrT aAddr,
    input  wire masterPkg::dataT aData,
    input  wire logic           bWe,
    input  wire masterPkg::addrT bAddr,
    input  wire masterPkg::dataT bData,
    output masterPkg::dataT     bQ
);

    masterPkg::dataT mem [masterPkg::memDepth];

    // port a writes only, port b is write-first with one cycle of read latency
    always_ff @(posedge clk) begin
        if (aWe) begin
            mem[aAddr] <= aData;
        end
        if (bWe) begin
            mem[bAddr] <= bData;
            bQ <= bData;
        end else begin
            bQ <= mem[bAddr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/cmdLoader.sv
`timescale 1ns/10ps
`default_nettype none

module cmdLoader (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              start,
    input  wire logic              rdWr,
    input  wire masterPkg::slaveIdT slaveId,
    input  wire masterPkg::addrT    address,
    input  wire masterPkg::dataT    data,
    input  wire logic              busy,
    output logic                   cmdValid,
    output logic                   cmdRdWr,
    output masterPkg::slaveIdT     cmdSlaveId,
    output masterPkg::addrT        cmdAddress,
    output logic                   ramWe,
    output masterPkg::addrT        ramAddr,
    output masterPkg::dataT        ramData
);

    logic accept;

    // a start in the cmdValid cycle is also dropped, the sequencer is not busy yet
    assign accept = start && !busy && !cmdValid;

    ////////////////////
    // control
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cmdValid <= 1'b0;
            ramWe <= 1'b0;
        end else begin
            cmdValid <= accept;
            // rdWr high is a write, keep a local copy of the word
            ramWe <= accept && rdWr;
        end
    end

    ////////////////////
    // command payload
    ////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            cmdRdWr <= rdWr;
            cmdSlaveId <= slaveId;
            cmdAddress <= address;
            ramAddr <= address;
            ramData <= data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/serialShifter.sv
`timescale 1ns/10ps
`default_nettype none

module serialShifter #(
    parameter type payloadT = logic [7:0]
) (
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire logic    load,
    input  wire payloadT loadValue,
    input  wire logic    shift,
    input  wire logic    bitIn,
    output logic         bitOut,
    output payloadT      word,
    output logic         lastBit
);

    localparam int width = $bits(payloadT);
    localparam int countWidth = $clog2(width + 1);

    logic [width-1:0]      bits;
    logic [countWidth-1:0] count;

    // payload, msb leaves first
    always_ff @(posedge clk) begin
        if (load) begin
            bits <= loadValue;
        end else if (shift) begin
            bits <= {bits[width-2:0], bitIn};
        end
    end

    // bits still to go
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= countWidth'(width);
        end else if (shift && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign bitOut = bits[width-1];
    assign word = payloadT'(bits);
    assign lastBit = (count == countWidth'(1));

endmodule

`default_nettype wire

// File: verilog/arbRequester.sv
`timescale 1ns/10ps
`default_nettype none

module arbRequester (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              request,
    input  wire masterPkg::slaveIdT slaveId,
    input  wire logic              arbCont,
    input  wire logic              releaseBus,
    output logic                   arbSend,
    output logic                   granted
);

    typedef enum logic [2:0] {
        reqIdle, reqWaitLow, reqSend, reqCount, reqHold
    } reqStateT;

    reqStateT state;
    logic [$clog2(masterPkg::grantSamples)-1:0] highCount;
    logic frameBit;
    logic frameLast;
    logic frameShift;

    assign frameShift = (state == reqSend);

    serialShifter #(
        .payloadT(masterPkg::requestT)
    ) frameShifter (
        .clk      (clk),
        .rstN     (rstN),
        .load     (state == reqIdle && request),
        .loadValue(masterPkg::requestT'{code: masterPkg::startCode, slaveId: slaveId}),
        .shift    (frameShift),
        .bitIn    (1'b0),
        .bitOut   (frameBit),
        .word     (),
        .lastBit  (frameLast)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= reqIdle;
            arbSend <= 1'b0;
            granted <= 1'b0;
            highCount <= '0;
        end else begin
            case (state)
                reqIdle: if (request) state <= reqWaitLow;
                // bus must be quiet before the frame goes out
                reqWaitLow: if (!arbCont) state <= reqSend;
                reqSend: begin
                    arbSend <= frameBit;
                    if (frameLast) begin
                        state <= reqCount;
                        highCount <= '0;
                    end
                end
                reqCount: begin
                    arbSend <= 1'b0;
                    if (!arbCont) begin
                        highCount <= '0;
                    end else if (highCount == $bits(highCount)'(masterPkg::grantSamples - 1)) begin
                        state <= reqHold;
                        arbSend <= 1'b1;
                        granted <= 1'b1;
                    end else begin
                        highCount <= highCount + 1'b1;
                    end
                end
                reqHold: begin
                    // own the bus until the transfer ends
                    if (releaseBus) begin
                        state <= reqIdle;
                        arbSend <= 1'b0;
                        granted <= 1'b0;
                    end
                end
                default: state <= reqIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/busSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module busSequencer (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              cmdValid,
    input  wire logic              cmdRdWr,
    input  wire masterPkg::slaveIdT cmdSlaveId,
    input  wire masterPkg::addrT    cmdAddress,
    input  wire logic              granted,
    input  wire logic              arbCont,
    input  wire logic              rD,
    input  wire logic              ready,
    input  wire masterPkg::dataT    ramQ,
    output logic                   busy,
    output logic                   requestBus,
    output logic                   releaseBus,
    output logic                   control,
    output logic                   wrD,
    output logic                   valid,
    output logic                   last,
    output logic                   ramWe,
    output masterPkg::addrT        ramAddr,
    output masterPkg::dataT        ramData,
    output logic                   doneCom,
    output masterPkg::dataT        dataOut
);

    masterPkg::seqStateT state;
    logic            rdWrReg;
    masterPkg::addrT addrReg;

    logic hdrLoad, hdrShift, hdrBit, hdrLast;
    logic datLoad, datShift, datBit, datLast;
    masterPkg::dataT datWord;

    ////////////////////
    // shifters
    ////////////////////
    assign hdrLoad = (state == masterPkg::idle) && cmdValid;
    // a high arbCont holds the header back
    assign hdrShift = (state == masterPkg::header) && !arbCont;

    serialShifter #(
        .payloadT(masterPkg::headerT)
    ) hdrShifter (
        .clk      (clk),
        .rstN     (rstN),
        .load     (hdrLoad),
        .loadValue(masterPkg::headerT'{code: masterPkg::startCode, slaveId: cmdSlaveId,
                                       rdWr: cmdRdWr, address: cmdAddress}),
        .shift    (hdrShift),
        .bitIn    (1'b0),
        .bitOut   (hdrBit),
        .word     (),
        .lastBit  (hdrLast)
    );

    // same register sends write data and collects read data
    assign datLoad = (state == masterPkg::waitBus) && granted;
    assign datShift = (state == masterPkg::writeData || state == masterPkg::readData) && ready;

    serialShifter #(
        .payloadT(masterPkg::dataT)
    ) datShifter (
        .clk      (clk),
        .rstN     (rstN),
        .load     (datLoad),
        .loadValue(ramQ),
        .shift    (datShift),
        .bitIn    (rD),
        .bitOut   (datBit),
        .word     (datWord),
        .lastBit  (datLast)
    );

    ////////////////////
    // transfer FSM
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= masterPkg::idle;
        end else begin
            case (state)
                masterPkg::idle: if (cmdValid) state <= masterPkg::request;
                masterPkg::request: state <= masterPkg::waitBus;
                masterPkg::waitBus: if (granted) state <= masterPkg::header;
                masterPkg::header: begin
                    if (hdrShift && hdrLast) begin
                        state <= rdWrReg ? masterPkg::writeData : masterPkg::readData;
                    end
                end
                masterPkg::writeData, masterPkg::readData: begin
                    if (datShift && datLast) state <= masterPkg::store;
                end
                masterPkg::store: state <= masterPkg::finish;
                default: state <= masterPkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdrLoad) begin
            rdWrReg <= cmdRdWr;
            addrReg <= cmdAddress;
        end
    end

    ////////////////////
    // outputs
    ////////////////////
    assign busy = (state != masterPkg::idle);
    assign requestBus = (state == masterPkg::request);
    assign releaseBus = (state == masterPkg::finish);

    assign control = hdrShift && hdrBit;
    assign wrD = (state == masterPkg::writeData) && datBit;
    assign valid = hdrShift || (state == masterPkg::writeData);
    assign last = (state == masterPkg::writeData) && datLast;

    // port b stays on the command address, so ramQ tracks that word
    assign ramAddr = addrReg;
    assign ramData = datWord;
    // only a read puts new data into memory
    assign ramWe = (state == masterPkg::store) && !rdWrReg;

    assign doneCom = (state == masterPkg::finish);
    assign dataOut = ramQ;

endmodule

`default_nettype wire

// File: verilog/busMaster.sv
`timescale 1ns/10ps
`default_nettype none

module busMaster (
    input  wire logic              clk,
    input  wire logic              rstN,

    ////////////////////
    // host
    ////////////////////
    input  wire logic              start,
    input  wire logic              rdWr,
    input  wire masterPkg::slaveIdT slaveId,
    input  wire masterPkg::addrT    address,
    input  wire masterPkg::dataT    data,
    output logic                   doneCom,
    output masterPkg::dataT        dataOut,

    ////////////////////
    // slave
    ////////////////////
    input  wire logic              rD,
    input  wire logic              ready,
    output logic                   control,
    output logic                   wrD,
    output logic                   valid,
    output logic                   last,

    ////////////////////
    // arbiter
    ////////////////////
    input  wire logic              arbCont,
    output logic                   arbSend
);

    logic               cmdValid;
    logic               cmdRdWr;
    masterPkg::slaveIdT cmdSlaveId;
    masterPkg::addrT    cmdAddress;
    logic               busy;

    // port a from the loader, port b from the sequencer
    logic            aWe, bWe;
    masterPkg::addrT aAddr, bAddr;
    masterPkg::dataT aData, bData, bQ;

    logic requestBus, releaseBus, granted;

    cmdLoader loader (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .rdWr      (rdWr),
        .slaveId   (slaveId),
        .address   (address),
        .data      (data),
        .busy      (busy),
        .cmdValid  (cmdValid),
        .cmdRdWr   (cmdRdWr),
        .cmdSlaveId(cmdSlaveId),
        .cmdAddress(cmdAddress),
        .ramWe     (aWe),
        .ramAddr   (aAddr),
        .ramData   (aData)
    );

    localRam ram (
        .clk  (clk),
        .aWe  (aWe),
        .aAddr(aAddr),
        .aData(aData),
        .bWe  (bWe),
        .bAddr(bAddr),
        .bData(bData),
        .bQ   (bQ)
    );

    arbRequester requester (
        .clk       (clk),
        .rstN      (rstN),
        .request   (requestBus),
        .slaveId   (cmdSlaveId),
        .arbCont   (arbCont),
        .releaseBus(releaseBus),
        .arbSend   (arbSend),
        .granted   (granted)
    );

    busSequencer sequencer (
        .clk       (clk),
        .rstN      (rstN),
        .cmdValid  (cmdValid),
        .cmdRdWr   (cmdRdWr),
        .cmdSlaveId(cmdSlaveId),
        .cmdAddress(cmdAddress),
        .granted   (granted),
        .arbCont   (arbCont),
        .rD        (rD),
        .ready     (ready),
        .ramQ      (bQ),
        .busy      (busy),
        .requestBus(requestBus),
        .releaseBus(releaseBus),
        .control   (control),
        .wrD       (wrD),
        .valid     (valid),
        .last      (last),
        .ramWe     (bWe),
        .ramAddr   (bAddr),
        .ramData   (bData),
        .doneCom   (doneCom),
        .dataOut   (dataOut)
    );

endmodule

`default_nettype wire

// File: bench/busModel.sv
`timescale 1ns/10ps
`default_nettype none

module busModel (
    input  wire logic  clk,
    input  wire logic  rstN,
    input  wire logic  arbSend,
    input  wire logic  control,
    input  wire logic  valid,
    input  wire logic  wrD,
    input  wire logic  last,
    output logic       arbCont,
    output logic       ready,
    output logic       rD,
    output logic [4:0]  frameWord,
    output logic [13:0] headerWord,
    output logic [15:0] wrWord,
    output int         frameCount,
    output int         lastErrors
);

    typedef enum {mIdle, mFrame, mDelay, mGrant, mHeader, mData, mEnd} phaseT;

    phaseT       phase;
    int          seed;
    int          bitCount;
    int          delayLeft;
    logic [15:0] rdWord;

    // inputs change on the falling edge, outputs are sampled just after
    initial begin
        seed = 38961;
        phase = mIdle;
        arbCont = 1'b0;
        ready = 1'b0;
        rD = 1'b0;
        frameWord = '0;
        headerWord = '0;
        wrWord = '0;
        frameCount = 0;
        lastErrors = 0;
        bitCount = 0;
        delayLeft = 0;
        rdWord = '0;
        forever begin
            @(negedge clk);
            if (!rstN) begin
                phase = mIdle;
                arbCont = 1'b0;
                ready = 1'b0;
            end else begin
                ////////////////////
                // drive
                ////////////////////
                case (phase)
                    mDelay: begin
                        if (delayLeft == 0) begin
                            arbCont = 1'b1;
                            phase = mGrant;
                        end else begin
                            delayLeft--;
                        end
                    end
                    // random pauses of the header
                    mHeader: arbCont = (($random(seed) & 3) == 0);
                    mData: begin
                        arbCont = 1'b0;
                        ready = (($random(seed) & 3) != 0);
                        rD = rdWord[15 - bitCount];
                    end
                    mIdle, mEnd: begin
                        arbCont = 1'b0;
                        ready = 1'b0;
                    end
                    default: ;
                endcase
                #1;
                ////////////////////
                // sample
                ////////////////////
                case (phase)
                    mIdle: begin
                        // frame always opens with a one
                        if (arbSend) begin
                            frameWord = 5'b00001;
                            bitCount = 1;
                            phase = mFrame;
                        end
                    end
                    mFrame: begin
                        frameWord = {frameWord[3:0], arbSend};
                        bitCount++;
                        if (bitCount == 5) begin
                            frameCount++;
                            delayLeft = $random(seed) & 3;
                            phase = mDelay;
                        end
                    end
                    // arbSend high again means the master took the grant
                    mGrant: begin
                        if (arbSend) begin
                            bitCount = 0;
                            phase = mHeader;
                        end
                    end
                    mHeader: begin
                        if (valid) begin
                            headerWord = {headerWord[12:0], control};
                            bitCount++;
                            if (bitCount == 14) begin
                                bitCount = 0;
                                rdWord = {headerWord[7:0], ~headerWord[7:0]};
                                phase = mData;
                            end
                        end
                    end
                    mData: begin
                        if (ready) begin
                            if (headerWord[8]) begin
                                wrWord = {wrWord[14:0], wrD};
                                if (last != (bitCount == 15)) lastErrors++;
                            end
                            bitCount++;
                            if (bitCount == 16) phase = mEnd;
                        end
                    end
                    mEnd: if (!arbSend) phase = mIdle;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/busMasterTb.sv
`timescale 1ns/10ps
`default_nettype none

module busMasterTb;

    localparam int doneTimeout = 2000;

    logic               clk;
    logic               rstN;
    logic               start;
    logic               rdWr;
    masterPkg::slaveIdT slaveId;
    masterPkg::addrT    address;
    masterPkg::dataT    data;
    logic               doneCom;
    masterPkg::dataT    dataOut;
    logic               rD, ready, control, wrD, valid, last, arbCont, arbSend;
    logic [4:0]         frameWord;
    logic [13:0]        headerWord;
    logic [15:0]        wrWord;
    int                 frameCount, lastErrors;

    int   seed;
    int   testsRun, testsFailed, errors, testErrors;
    logic timedOut;

    busMaster DUT (
        .clk(clk), .rstN(rstN), .start(start), .rdWr(rdWr), .slaveId(slaveId),
        .address(address), .data(data), .doneCom(doneCom), .dataOut(dataOut),
        .rD(rD), .ready(ready), .control(control), .wrD(wrD), .valid(valid),
        .last(last), .arbCont(arbCont), .arbSend(arbSend)
    );

    busModel model (
        .clk(clk), .rstN(rstN), .arbSend(arbSend), .control(control), .valid(valid),
        .wrD(wrD), .last(last), .arbCont(arbCont), .ready(ready), .rD(rD),
        .frameWord(frameWord), .headerWord(headerWord), .wrWord(wrWord),
        .frameCount(frameCount), .lastErrors(lastErrors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        testsRun++;
        errors += testErrors;
        if (testErrors != 0) testsFailed++;
        $display("test %0d %s: %s", testsRun, name, (testErrors == 0) ? "pass" : "FAIL");
    endtask

    ////////////////////
    // one transfer
    ////////////////////
    task automatic runTransfer(input string name, input logic wr, input logic [1:0] sid,
                               input logic [7:0] addr, input logic [15:0] dat,
                               input logic withExtra);
        int          framesBefore;
        int          lastBefore;
        int          cycles;
        logic [15:0] expOut;
        if (timedOut) return;
        testErrors = 0;
        framesBefore = frameCount;
        lastBefore = lastErrors;
        @(negedge clk);
        start = 1'b1;
        rdWr = wr;
        slaveId = sid;
        address = addr;
        data = dat;
        @(negedge clk);
        start = 1'b0;
        // second write to the same address while busy must leave no trace
        if (withExtra) begin
            repeat (3) @(negedge clk);
            start = 1'b1;
            rdWr = 1'b1;
            slaveId = ~sid;
            address = addr;
            data = ~dat;
            @(negedge clk);
            start = 1'b0;
        end
        cycles = 0;
        while (!doneCom && cycles < doneTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!doneCom) begin
            $display("%s: no doneCom within %0d cycles", name, doneTimeout);
            timedOut = 1'b1;
            testErrors++;
        end else begin
            // read word holds the address in the high byte and its inverse below
            expOut = wr ? dat : {addr, ~addr};
            checkValue("arbSend frame", 32'(frameWord), 32'({masterPkg::startCode, sid}));
            checkValue("frameCount", 32'(frameCount), 32'(framesBefore + 1));
            checkValue("control header", 32'(headerWord),
                       32'({masterPkg::startCode, sid, wr, addr}));
            if (wr) begin
                checkValue("wrD word", 32'(wrWord), 32'(dat));
                checkValue("last errors", 32'(lastErrors), 32'(lastBefore));
            end
            checkValue("dataOut", 32'(dataOut), 32'(expOut));
            if (withExtra) begin
                // no frame may follow in the quiet period
                repeat (40) @(negedge clk);
                checkValue("frameCount idle", 32'(frameCount), 32'(framesBefore + 1));
            end
        end
        endTest(name);
    endtask

    initial begin
        seed = 38961;
        testsRun = 0;
        testsFailed = 0;
        errors = 0;
        testErrors = 0;
        timedOut = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        rdWr = 1'b0;
        slaveId = '0;
        address = '0;
        data = '0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;

        @(negedge clk);
        checkValue("control", 32'(control), 32'd0);
        checkValue("wrD", 32'(wrD), 32'd0);
        checkValue("valid", 32'(valid), 32'd0);
        checkValue("last", 32'(last), 32'd0);
        checkValue("arbSend", 32'(arbSend), 32'd0);
        checkValue("doneCom", 32'(doneCom), 32'd0);
        endTest("reset values");

        runTransfer("write", 1'b1, 2'd1, 8'h3c, 16'ha5c3, 1'b0);
        runTransfer("read same address", 1'b0, 2'd2, 8'h3c, 16'h0000, 1'b0);
        runTransfer("read", 1'b0, 2'd3, 8'h81, 16'h0000, 1'b0);
        runTransfer("write with busy start", 1'b1, 2'd0, 8'h10, 16'h1234, 1'b1);
        runTransfer("read with busy start", 1'b0, 2'd1, 8'hf0, 16'h0000, 1'b1);
        for (int i = 0; i < 6; i++) begin
            runTransfer("random", 1'($random(seed)), 2'($random(seed)),
                        8'($random(seed)), 16'($random(seed)), 1'b0);
        end

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0 && !timedOut) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/masterPkg.sv
verilog/localRam.sv
verilog/cmdLoader.sv
verilog/serialShifter.sv
verilog/arbRequester.sv
verilog/busSequencer.sv
verilog/busMaster.sv
bench/busModel.sv
bench/busMasterTb.sv

// File: run.sh
#!/bin/sh
# build and run the busMaster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module busMasterTb -f list.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VbusMasterTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator returned status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
